//--- Bender.yml
package:
  name: ram_loader

sources:
  - logic/loader_pkg.sv
  - logic/cfg_deserializer.sv
  - logic/byte_fifo.sv
  - logic/wb_byte_writer.sv
  - logic/ram_loader_top.sv
  - target: test
    files:
      - test/ram_loader_assert.sv
      - test/ram_loader_tb.sv

//--- logic/byte_fifo.sv
//****************************************************************************
// circular FIFO of pending byte writes with sticky overflow flag
//****************************************************************************
`timescale 1ns/1ps
`default_nettype none

module byte_fifo (
   input  wire                  clk_i,
   input  wire                  rst_i,
   input  wire                  push_i,
   input  loader_pkg::byte_wr_t push_item_i,
   input  wire                  pop_i,
   output loader_pkg::byte_wr_t head_o,
   output logic                 empty_o,
   output logic                 overflow_o
);
   import loader_pkg::*;

   byte_wr_t            mem_q [FIFO_DEPTH];
   logic [FIFO_PTR_W-1:0] wr_ptr_q;
   logic [FIFO_PTR_W-1:0] rd_ptr_q;
   logic [FIFO_CNT_W-1:0] count_q;
   logic                  full;
   logic                  do_push;
   logic                  do_pop;
   logic                  overflow_q;

   assign full    = (count_q == FIFO_CNT_W'(FIFO_DEPTH));
   assign empty_o = (count_q == '0);
   assign do_push = push_i && !full;   // dropped when full
   assign do_pop  = pop_i && !empty_o;

   always_ff @(posedge clk_i)
   begin
      if (do_push)
         mem_q[wr_ptr_q] <= push_item_i;
   end

   always_ff @(posedge clk_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         wr_ptr_q   <= '0;
         rd_ptr_q   <= '0;
         count_q    <= '0;
         overflow_q <= 1'b0;
      end
      else
      begin
         if (do_push)
            wr_ptr_q <= (wr_ptr_q == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         if (do_pop)
            rd_ptr_q <= (rd_ptr_q == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         if (do_push && !do_pop)
            count_q <= count_q + 1'b1;
         else if (do_pop && !do_push)
            count_q <= count_q - 1'b1;
         if (push_i && full)
            overflow_q <= 1'b1;   // sticky
      end
   end

   assign head_o     = mem_q[rd_ptr_q];
   assign overflow_o = overflow_q;

endmodule

`default_nettype wire

//--- logic/cfg_deserializer.sv
//****************************************************************************
// config clock synchronizer, serial shift register, byte addressing, start FSM
//****************************************************************************
`timescale 1ns/1ps
`default_nettype none

module cfg_deserializer (
   input  wire                 clk_i,
   input  wire                 rst_i,
   input  wire                 cfg_clk_i,
   input  wire                 cfg_data_i,
   input  wire                 detached_i,
   input  wire                 all_written_i,
   output logic                push_o,
   output loader_pkg::byte_wr_t push_item_o,
   output logic                start_o
);
   import loader_pkg::*;

   logic [1:0]        cfg_clk_sync_q;
   logic [1:0]        cfg_dat_sync_q;
   logic [1:0]        det_sync_q;
   logic              cfg_clk_prev_q;
   logic              cfg_rise;
   logic              take_bit;
   logic [7:0]        shift_q;
   logic [2:0]        bit_cnt_q;
   logic [ADDR_W-1:0] addr_q;
   logic              addr_full;
   logic              push_q;
   byte_wr_t          item_q;
   start_state_e      state_q;
   start_state_e      state_d;

   // two-flop synchronizers, data rides alongside the clock
   always_ff @(posedge clk_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         cfg_clk_sync_q <= 2'b00;
         cfg_dat_sync_q <= 2'b00;
         det_sync_q     <= 2'b00;
         cfg_clk_prev_q <= 1'b0;
      end
      else
      begin
         cfg_clk_sync_q <= {cfg_clk_sync_q[0], cfg_clk_i};
         cfg_dat_sync_q <= {cfg_dat_sync_q[0], cfg_data_i};
         det_sync_q     <= {det_sync_q[0], detached_i};
         cfg_clk_prev_q <= cfg_clk_sync_q[1];
      end
   end

   assign cfg_rise  = cfg_clk_sync_q[1] & ~cfg_clk_prev_q;
   assign addr_full = (addr_q == ADDR_W'(LOAD_BYTES));
   assign take_bit  = cfg_rise && (state_q == ST_RUN) && !addr_full;

   // msb first
   always_ff @(posedge clk_i)
   begin
      if (take_bit)
         shift_q <= {shift_q[6:0], cfg_dat_sync_q[1]};
   end

   always_ff @(posedge clk_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         bit_cnt_q <= 3'd0;
         push_q    <= 1'b0;
         addr_q    <= '0;
      end
      else
      begin
         push_q <= take_bit && (bit_cnt_q == 3'd7);  // byte complete
         if (take_bit)
            bit_cnt_q <= bit_cnt_q + 3'd1;
         if (push_q)
            addr_q <= addr_q + ADDR_W'(1);
      end
   end

   // item captured with the last bit, pushed on the following cycle
   always_ff @(posedge clk_i)
   begin
      if (take_bit && (bit_cnt_q == 3'd7))
      begin
         item_q.addr <= addr_q;
         item_q.data <= {shift_q[6:0], cfg_dat_sync_q[1]};
      end
   end

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         ST_WAIT_DETACH:
            if (det_sync_q[1])
               state_d = ST_RUN;
         ST_RUN:
            if (all_written_i)
               state_d = ST_DONE;
         ST_DONE:
            state_d = ST_DONE;  // held until reset
         default:
            state_d = ST_WAIT_DETACH;
      endcase
   end

   always_ff @(posedge clk_i or posedge rst_i)
   begin
      if (rst_i)
         state_q <= ST_WAIT_DETACH;
      else
         state_q <= state_d;
   end

   assign start_o     = (state_q == ST_RUN);
   assign push_o      = push_q;
   assign push_item_o = item_q;

endmodule

`default_nettype wire

//--- logic/loader_pkg.sv
//****************************************************************************
// loader sizes, control and bus state enums, pending byte-write struct
//****************************************************************************
`default_nettype none

package loader_pkg;

   // byte address width on the bus
   localparam int ADDR_W = 16;

   // bytes in one load, small for simulation
   localparam int LOAD_BYTES = 64;

   localparam int FIFO_DEPTH = 4;

   // counter widths derived from the sizes above
   localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
   localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);
   localparam int BYTE_CNT_W = $clog2(LOAD_BYTES + 1);

   // one pending write, 24 bits
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [7:0]        data;
   } byte_wr_t;

   // start/done control
   typedef enum logic [1:0] {
      ST_WAIT_DETACH = 2'd0,
      ST_RUN         = 2'd1,
      ST_DONE        = 2'd2
   } start_state_e;

   // wishbone write master
   typedef enum logic {
      BUS_IDLE  = 1'b0,
      BUS_WRITE = 1'b1
   } bus_state_e;

endpackage

`default_nettype wire

//--- logic/ram_loader_top.sv
//****************************************************************************
// boot RAM loader top: deserializer, byte FIFO and wishbone writer
//****************************************************************************
`timescale 1ns/1ps
`default_nettype none

module ram_loader_top (
   input  wire                           clk_i,
   input  wire                           rst_i,
   input  wire                           cfg_clk_i,   // async to clk_i
   input  wire                           cfg_data_i,
   input  wire                           detached_i,
   output logic                          start_o,
   output logic                          mode_o,
   output logic                          done_o,
   output logic                          loader_done_o,
   output logic                          overflow_o,
   output logic [loader_pkg::ADDR_W-1:0] wb_adr_o,
   output logic [31:0]                   wb_dat_o,
   output logic [3:0]                    wb_sel_o,
   output logic                          wb_we_o,
   output logic                          wb_stb_o,
   output logic                          wb_cyc_o,
   input  wire                           wb_ack_i
);
   import loader_pkg::*;

   logic     push;
   byte_wr_t push_item;
   logic     pop;
   logic     empty;
   byte_wr_t head;
   logic     all_written;

   cfg_deserializer u_deser (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .cfg_clk_i     (cfg_clk_i),
      .cfg_data_i    (cfg_data_i),
      .detached_i    (detached_i),
      .all_written_i (all_written),
      .push_o        (push),
      .push_item_o   (push_item),
      .start_o       (start_o)
   );

   byte_fifo u_fifo (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .push_i      (push),
      .push_item_i (push_item),
      .pop_i       (pop),
      .head_o      (head),
      .empty_o     (empty),
      .overflow_o  (overflow_o)
   );

   wb_byte_writer u_writer (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .empty_i       (empty),
      .head_i        (head),
      .wb_ack_i      (wb_ack_i),
      .pop_o         (pop),
      .wb_adr_o      (wb_adr_o),
      .wb_dat_o      (wb_dat_o),
      .wb_sel_o      (wb_sel_o),
      .wb_we_o       (wb_we_o),
      .wb_stb_o      (wb_stb_o),
      .wb_cyc_o      (wb_cyc_o),
      .all_written_o (all_written),
      .loader_done_o (loader_done_o)
   );

   assign mode_o = loader_done_o;
   // done reads high while the loader is not running
   assign done_o = start_o ? loader_done_o : 1'b1;

endmodule

`default_nettype wire

//--- logic/wb_byte_writer.sv
//****************************************************************************
// write-only wishbone master, one single cycle per queued byte
//****************************************************************************
`timescale 1ns/1ps
`default_nettype none

module wb_byte_writer (
   input  wire                           clk_i,
   input  wire                           rst_i,
   input  wire                           empty_i,
   input  loader_pkg::byte_wr_t          head_i,
   input  wire                           wb_ack_i,
   output logic                          pop_o,
   output logic [loader_pkg::ADDR_W-1:0] wb_adr_o,
   output logic [31:0]                   wb_dat_o,
   output logic [3:0]                    wb_sel_o,
   output logic                          wb_we_o,
   output logic                          wb_stb_o,
   output logic                          wb_cyc_o,
   output logic                          all_written_o,
   output logic                          loader_done_o
);
   import loader_pkg::*;

   bus_state_e            state_q;
   logic [ADDR_W-1:0]     adr_q;
   logic [7:0]            dat_q;
   logic [3:0]            sel_q;
   logic [BYTE_CNT_W-1:0] wr_cnt_q;
   logic                  done_q;

   assign pop_o = (state_q == BUS_IDLE) && !empty_i;

   always_ff @(posedge clk_i)
   begin
      if (pop_o)
      begin
         adr_q <= head_i.addr;
         dat_q <= head_i.data;
      end
   end

   always_ff @(posedge clk_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         state_q  <= BUS_IDLE;
         sel_q    <= 4'b0000;
         wr_cnt_q <= '0;
         done_q   <= 1'b0;
      end
      else
      begin
         case (state_q)
            BUS_IDLE:
               if (pop_o)
               begin
                  state_q <= BUS_WRITE;
                  case (head_i.addr[1:0])   // big endian lanes
                     2'b00:   sel_q <= 4'b1000;
                     2'b01:   sel_q <= 4'b0100;
                     2'b10:   sel_q <= 4'b0010;
                     default: sel_q <= 4'b0001;
                  endcase
               end
            BUS_WRITE:
               if (wb_ack_i)
               begin
                  state_q  <= BUS_IDLE;
                  wr_cnt_q <= wr_cnt_q + 1'b1;
                  if (wr_cnt_q == BYTE_CNT_W'(LOAD_BYTES - 1))
                     done_q <= 1'b1;   // last byte acked
               end
            default:
               state_q <= BUS_IDLE;
         endcase
      end
   end

   // stb, cyc and we share one level
   assign wb_stb_o = (state_q == BUS_WRITE);
   assign wb_cyc_o = (state_q == BUS_WRITE);
   assign wb_we_o  = (state_q == BUS_WRITE);
   assign wb_adr_o = adr_q;
   assign wb_dat_o = {4{dat_q}};   // byte on every lane
   assign wb_sel_o = sel_q;

   assign all_written_o = (wr_cnt_q == BYTE_CNT_W'(LOAD_BYTES));
   assign loader_done_o = done_q;

endmodule

`default_nettype wire

//--- sim.f
logic/loader_pkg.sv
logic/cfg_deserializer.sv
logic/byte_fifo.sv
logic/wb_byte_writer.sv
logic/ram_loader_top.sv
test/ram_loader_assert.sv
test/ram_loader_tb.sv

//--- test/ram_loader_assert.sv
//****************************************************************************
// wishbone write cycle checks, bound into the byte writer
//****************************************************************************
`timescale 1ns/1ps
`default_nettype none

module ram_loader_assert (
   input wire                          clk_i,
   input wire                          rst_i,
   input wire                          stb_i,
   input wire                          cyc_i,
   input wire                          we_i,
   input wire                          ack_i,
   input wire [loader_pkg::ADDR_W-1:0] adr_i,
   input wire [31:0]                   dat_i,
   input wire [3:0]                    sel_i
);

   int unsigned fail_cnt = 0;   // failed assertions so far

   // stb, cyc and we move as one
   strobe_together: assert property (@(posedge clk_i) disable iff (rst_i)
      (stb_i == cyc_i) && (cyc_i == we_i))
   else
   begin
      $error("stb, cyc and we differ");
      fail_cnt++;
   end

   hold_until_ack: assert property (@(posedge clk_i) disable iff (rst_i)
      stb_i && !ack_i |=> stb_i && $stable(adr_i) && $stable(dat_i) && $stable(sel_i))
   else
   begin
      $error("write cycle changed or dropped before ack");
      fail_cnt++;
   end

   release_after_ack: assert property (@(posedge clk_i) disable iff (rst_i)
      stb_i && ack_i |=> !stb_i)
   else
   begin
      $error("stb still high on the edge after ack");
      fail_cnt++;
   end

   // big endian lane, address 0 on the top byte
   one_lane: assert property (@(posedge clk_i) disable iff (rst_i)
      stb_i |-> $onehot(sel_i) && (sel_i == (4'b1000 >> adr_i[1:0])))
   else
   begin
      $error("select is not the single lane of the address");
      fail_cnt++;
   end

endmodule

bind wb_byte_writer ram_loader_assert u_assert (
   .clk_i (clk_i),
   .rst_i (rst_i),
   .stb_i (wb_stb_o),
   .cyc_i (wb_cyc_o),
   .we_i  (wb_we_o),
   .ack_i (wb_ack_i),
   .adr_i (wb_adr_o),
   .dat_i (wb_dat_o),
   .sel_i (wb_sel_o)
);

`default_nettype wire

//--- test/ram_loader_tb.sv
//****************************************************************************
// ram loader testbench: clock, reset, serial stimulus, wishbone slave model
// with random ack delay, write checks and the closing report
//****************************************************************************
`timescale 1ns/1ps
`default_nettype none

module ram_loader_tb;
   import loader_pkg::*;

   logic              clk_i;
   logic              rst_i;
   logic              cfg_clk_i;
   logic              cfg_data_i;
   logic              detached_i;
   logic              wb_ack_i;
   logic              start_o;
   logic              mode_o;
   logic              done_o;
   logic              loader_done_o;
   logic              overflow_o;
   logic [ADDR_W-1:0] wb_adr_o;
   logic [31:0]       wb_dat_o;
   logic [3:0]        wb_sel_o;
   logic              wb_we_o;
   logic              wb_stb_o;
   logic              wb_cyc_o;

   logic [31:0] lfsr_q;
   logic [7:0]  load_data [LOAD_BYTES];
   int          write_cnt;
   int          mismatches;
   int          failures;
   int          assert_fails;
   logic [3:0]  watch;   // conditions the waits can poll

   ram_loader_top dut (.*);

   assign watch = {write_cnt == LOAD_BYTES, loader_done_o, !start_o, start_o};

   always #5 clk_i = ~clk_i;

   // galois lfsr, x^32 + x^22 + x^2 + x + 1
   function automatic logic rand_bit();
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
      return lfsr_q[0];
   endfunction

   // inputs change 1 ns after the rising edge
   task automatic next_cycle();
      @(posedge clk_i);
      #1;
   endtask

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      assert (act === exp)
      else
      begin
         $display("MISMATCH %s expected %0h actual %0h", name, exp, act);
         mismatches++;
      end
   endtask

   task automatic wait_for(input int idx, input int limit, input string what);
      int n;
      n = 0;
      while (!watch[idx] && n < limit)
      begin
         next_cycle();
         n++;
      end
      if (!watch[idx])
      begin
         $display("timeout after %0d cycles waiting for %s", limit, what);
         failures++;
      end
   endtask

   // msb first, config clock half period of 6 cycles
   task automatic send_byte(input logic [7:0] value);
      for (int b = 7; b >= 0; b--)
      begin
         cfg_clk_i  = 1'b0;
         cfg_data_i = value[b];
         repeat (6) next_cycle();
         cfg_clk_i = 1'b1;
         repeat (6) next_cycle();
      end
   endtask

   // slave memory, each write compared with the expected byte and lane
   initial
   begin : slave
      logic [1:0] delay;
      forever
      begin
         next_cycle();
         if (wb_stb_o)
         begin
            if (write_cnt >= LOAD_BYTES)
            begin
               $display("unexpected bus cycle to address %0h after the load", wb_adr_o);
               failures++;
            end
            else
            begin
               check_value("write address", write_cnt, wb_adr_o);
               check_value("write data", {4{load_data[write_cnt]}}, wb_dat_o);
               check_value("write select", 4'b1000 >> write_cnt[1:0], wb_sel_o);
            end
            write_cnt++;
            delay[1] = rand_bit();   // 0 to 3 wait cycles
            delay[0] = rand_bit();
            repeat (delay) next_cycle();
            wb_ack_i = 1'b1;
            next_cycle();
            wb_ack_i = 1'b0;
         end
      end
   end

   initial
   begin : main
      clk_i      = 1'b0;
      rst_i      = 1'b1;
      cfg_clk_i  = 1'b0;
      cfg_data_i = 1'b0;
      detached_i = 1'b0;
      wb_ack_i   = 1'b0;
      write_cnt  = 0;
      mismatches = 0;
      failures   = 0;
      lfsr_q     = 32'h3f6f2edb;
      for (int i = 0; i < LOAD_BYTES; i++)
         for (int b = 7; b >= 0; b--)
            load_data[i][b] = rand_bit();
      repeat (5) next_cycle();
      rst_i = 1'b0;

      check_value("reset start_o", 0, start_o);
      check_value("reset mode_o", 0, mode_o);
      check_value("reset loader_done_o", 0, loader_done_o);
      check_value("reset overflow_o", 0, overflow_o);
      check_value("reset bus strobes", 0, {wb_stb_o, wb_cyc_o, wb_we_o});
      check_value("reset wb_sel_o", 0, wb_sel_o);
      check_value("reset done_o", 1, done_o);

      detached_i = 1'b1;
      wait_for(0, 20, "start_o to rise");
      check_value("start done_o", 0, done_o);

      for (int i = 0; i < LOAD_BYTES; i++)
         send_byte(load_data[i]);
      wait_for(3, 100, "the last bus write");
      wait_for(2, 100, "loader_done_o to rise");
      wait_for(1, 20, "start_o to fall");
      check_value("done loader_done_o", 1, loader_done_o);
      check_value("done mode_o", 1, mode_o);
      check_value("done done_o", 1, done_o);
      check_value("done overflow_o", 0, overflow_o);

      // serial bits after completion
      send_byte(8'ha5);
      send_byte(8'h5a);
      repeat (20) next_cycle();
      check_value("writes after done", LOAD_BYTES, write_cnt);
      check_value("overflow after done", 0, overflow_o);

      assert_fails = dut.u_writer.u_assert.fail_cnt;
      $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
               mismatches, failures, assert_fails);
      if (mismatches != 0 || failures != 0 || assert_fails != 0)
         $display("Testbench failed");
      else
         $display("Testbench passed");
      $finish;
   end

endmodule

`default_nettype wire
